//--- files.f
src/rx_pkg.sv
src/buffer_pkg.sv
src/capture_control.sv
src/capture_buffer.sv
src/width_packer.sv
src/timetagging_sample_buffer.sv
bench/timetagging_tb.sv

//--- run.sh
#!/bin/sh
# builds the testbench with Verilator, runs it and scans the log for the fail message
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --top-module timetagging_tb -f files.f -o tb_sim > build.log 2>&1 &&
  ./obj_dir/tb_sim > sim.log 2>&1 ||
  { cat build.log sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "RESULT: FAIL" sim.log && exit 1 || exit 0

//--- bench/timetagging_tb.sv
// directed tests on one clock; sample and timestamp values are derived from the cycle count
`timescale 1ns/1ps
`default_nettype none

module timetagging_tb
  import rx_pkg::*;
  import buffer_pkg::*;
;

  localparam int CLK_HALF = 20;
  localparam int WAIT_LIMIT = 200;
  localparam int BEATS = 20;

  logic ps_clk = 1'b0;
  logic ps_reset;
  logic samples_valid, timestamps_valid, digital_trigger;
  sample_batch_t samples_data;
  tstamp_t timestamps_data;
  logic discriminator_reset;
  logic arm_start_stop_valid, arm_start_stop_ready;
  logic [2:0] arm_start_stop_data;
  logic readout_start_valid, readout_start_ready;
  logic capture_sw_reset, readout_sw_reset;
  logic readout_valid, readout_ready, readout_last;
  logic [AXI_MM_WIDTH-1:0] readout_data;
  logic [SAMPLE_DEPTH_WIDTH-1:0] samples_write_depth;
  logic [TSTAMP_DEPTH_WIDTH-1:0] timestamps_write_depth;

  integer seed = 32'h9096;
  int cyc = 0;
  int errors = 0;
  int tests = 0;
  int failed_tests = 0;
  int disc_count = 0;
  logic [AXI_MM_WIDTH-1:0] beats [24];

  timetagging_sample_buffer DUT (.*);

  always #CLK_HALF ps_clk = ~ps_clk;

  // cycle index, stable from just after each edge
  always @(posedge ps_clk) cyc <= cyc + 1;

  // realtime sources: batch {2c+1, 2c} every cycle, timestamp c/4 on every fourth cycle
  always @(posedge ps_clk) begin
    #1;
    samples_data = {16'(2 * cyc + 1), 16'(2 * cyc)};
    timestamps_valid = (cyc % 4 == 0);
    timestamps_data = 16'(cyc / 4);
  end

  // discriminator pulses counted away from the active edge
  always @(negedge ps_clk) begin
    if (discriminator_reset) disc_count <= disc_count + 1;
  end

  ////////////////////////////////////////
  // helpers
  ////////////////////////////////////////

  task automatic tick();
    @(posedge ps_clk);
    #1;
  endtask

  task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                             input string msg);
    if (actual !== expected) begin
      errors++;
      $display("Mismatch at %0t ns: %s (got %0h, expected %0h)", $time, msg, actual, expected);
    end
  endtask

  task automatic report_error(input string msg);
    errors++;
    $display("Error at %0t ns: %s", $time, msg);
  endtask

  task automatic close_test(input string name, input int errors_before);
    tests++;
    if (errors == errors_before) begin
      $display("test %s: ok", name);
    end else begin
      failed_tests++;
      $display("test %s: %0d errors", name, errors - errors_before);
    end
  endtask

  // returns the cycle in which the command was taken
  task automatic send_cmd(input logic [2:0] cmd, output int taken);
    int n;
    taken = -1;
    arm_start_stop_data = cmd;
    for (n = 0; n < WAIT_LIMIT && taken < 0; n++) begin
      arm_start_stop_valid = 1'b1;
      if (arm_start_stop_ready) taken = cyc;
      tick();
    end
    arm_start_stop_valid = 1'b0;
    if (taken < 0) report_error("command was never accepted");
  endtask

  task automatic start_readout();
    int n;
    bit taken;
    taken = 0;
    for (n = 0; n < WAIT_LIMIT && !taken; n++) begin
      readout_start_valid = 1'b1;
      taken = readout_start_ready;
      tick();
    end
    readout_start_valid = 1'b0;
    if (!taken) report_error("readout start was never accepted");
  endtask

  // takes beats until last, with ready either held high or random per cycle
  task automatic collect_readout(input bit random_ready, output int count);
    int n;
    bit done;
    count = 0;
    done = 0;
    for (n = 0; n < WAIT_LIMIT * 4 && !done; n++) begin
      readout_ready = random_ready ? $random(seed) & 1 : 1'b1;
      #1;
      if (readout_valid && readout_ready) begin
        beats[count] = readout_data;
        check_value(readout_last, count == BEATS - 1, $sformatf("last on beat %0d", count + 1));
        done = readout_last || (count == 23);
        count++;
      end
      @(posedge ps_clk);
      #1;
    end
    readout_ready = 1'b0;
    if (!done) report_error("readout stream stopped before its last beat");
    check_value(count, BEATS, "readout beat count");
    // the stream stays quiet once last has gone out
    repeat (4) begin
      check_value(readout_valid, 0, "beat after last");
      tick();
    end
  endtask

  // captured entries against the source pattern from capture start c0
  task automatic verify_readout(input int c0, input int sdepth, input int tdepth);
    int i;
    for (i = 0; i < tdepth; i++) begin
      check_value(beats[i / 4][16 * (i % 4) +: 16], 16'((c0 + 3) / 4 + i),
                  $sformatf("timestamp entry %0d", i));
    end
    for (i = 0; i < sdepth; i++) begin
      check_value(beats[4 + i / 2][32 * (i % 2) +: 32],
                  {16'(2 * (c0 + i) + 1), 16'(2 * (c0 + i))},
                  $sformatf("sample batch %0d", i));
    end
  endtask

  function automatic int ts_in_window(input int first, input int last);
    return last / 4 - (first + 3) / 4 + 1;
  endfunction

  // software start then stop after hold cycles; returns capture start and expected depths
  task automatic sw_capture(input int hold, output int c0, output int sdepth, output int tdepth);
    int t_start;
    int t_stop;
    send_cmd(3'b110, t_start);
    // start reaches the buffers DISC_LATENCY cycles after its discriminator reset
    c0 = t_start + 2 + DISC_LATENCY + 1;
    repeat (hold) tick();
    send_cmd(3'b001, t_stop);
    repeat (3) tick();
    sdepth = t_stop + 1 - c0 + 1;
    tdepth = ts_in_window(c0, t_stop + 1);
    check_value(samples_write_depth, sdepth, "samples write depth after stop");
    check_value(timestamps_write_depth, tdepth, "timestamps write depth after stop");
  endtask

  ////////////////////////////////////////
  // tests
  ////////////////////////////////////////

  int c0_trig;
  int tdepth_trig;

  task automatic test_reset();
    int e;
    e = errors;
    check_value(readout_valid, 0, "readout_valid after reset");
    check_value(readout_last, 0, "readout_last after reset");
    check_value(discriminator_reset, 0, "discriminator_reset after reset");
    check_value(samples_write_depth, 0, "samples depth after reset");
    check_value(timestamps_write_depth, 0, "timestamps depth after reset");
    check_value(arm_start_stop_ready, 1, "command ready after reset");
    check_value(readout_start_ready, 0, "readout start ready with nothing captured");
    close_test("reset", e);
  endtask

  task automatic test_sw_start_stop();
    int e, c0, sd, td, n, d0;
    e = errors;
    d0 = disc_count;
    sw_capture(20, c0, sd, td);
    check_value(disc_count - d0, 1, "discriminator reset pulses");
    start_readout();
    collect_readout(0, n);
    verify_readout(c0, sd, td);
    close_test("software start and stop", e);
  endtask

  task automatic test_trigger();
    int e, t, n, held;
    e = errors;
    send_cmd(3'b100, t);
    repeat (3) tick();
    digital_trigger = 1'b1;
    c0_trig = cyc + DISC_LATENCY + 1;
    #1;
    check_value(discriminator_reset, 1, "discriminator reset in trigger cycle");
    tick();
    digital_trigger = 1'b0;
    for (n = 0; n < WAIT_LIMIT && samples_write_depth != SAMPLE_BUFFER_DEPTH; n++) tick();
    if (samples_write_depth != SAMPLE_BUFFER_DEPTH) report_error("sample buffer never filled");
    tick();
    tdepth_trig = ts_in_window(c0_trig, c0_trig + SAMPLE_BUFFER_DEPTH - 1);
    check_value(timestamps_write_depth, tdepth_trig, "timestamps depth at sample fill");
    if (timestamps_write_depth > TSTAMP_BUFFER_DEPTH) report_error("timestamp depth over 16");
    held = timestamps_write_depth;
    repeat (10) begin
      tick();
      check_value(arm_start_stop_ready, 0, "command ready while holding");
      check_value(timestamps_write_depth, held, "timestamps depth while holding");
    end
    close_test("digital trigger", e);
  endtask

  task automatic test_random_ready();
    int e, n;
    e = errors;
    start_readout();
    collect_readout(1, n);
    verify_readout(c0_trig, SAMPLE_BUFFER_DEPTH, tdepth_trig);
    close_test("readout with random ready", e);
  endtask

  task automatic test_readout_restart();
    int e, c0, sd, td, n;
    bit got;
    e = errors;
    sw_capture(24, c0, sd, td);
    start_readout();
    got = 0;
    // take a single beat, then stall the stream
    for (n = 0; n < WAIT_LIMIT && !got; n++) begin
      readout_ready = 1'b1;
      #1;
      got = readout_valid;
      tick();
    end
    readout_ready = 1'b0;
    if (!got) report_error("no beat before the readout reset");
    readout_sw_reset = 1'b1;
    tick();
    readout_sw_reset = 1'b0;
    repeat (2) tick();
    start_readout();
    collect_readout(0, n);
    verify_readout(c0, sd, td);
    close_test("readout reset and restart", e);
  endtask

  task automatic test_capture_reset();
    int e, c0, sd, td, n;
    e = errors;
    sw_capture(16, c0, sd, td);
    check_value(arm_start_stop_ready, 0, "command ready while holding");
    capture_sw_reset = 1'b1;
    tick();
    capture_sw_reset = 1'b0;
    tick();
    check_value(samples_write_depth, 0, "samples depth after capture reset");
    check_value(timestamps_write_depth, 0, "timestamps depth after capture reset");
    check_value(arm_start_stop_ready, 1, "command ready after capture reset");
    sw_capture(12, c0, sd, td);
    start_readout();
    collect_readout(0, n);
    verify_readout(c0, sd, td);
    close_test("capture reset and new capture", e);
  endtask

  initial begin
    ps_reset = 1'b1;
    samples_valid = 1'b1;
    samples_data = '0;
    timestamps_valid = 1'b0;
    timestamps_data = '0;
    digital_trigger = 1'b0;
    arm_start_stop_valid = 1'b0;
    arm_start_stop_data = 3'b000;
    readout_start_valid = 1'b0;
    capture_sw_reset = 1'b0;
    readout_sw_reset = 1'b0;
    readout_ready = 1'b0;
    repeat (10) @(posedge ps_clk);
    #1;
    ps_reset = 1'b0;
    tick();
    test_reset();
    test_sw_start_stop();
    test_trigger();
    test_random_ready();
    test_readout_restart();
    test_capture_reset();
    $display("%0d tests, %0d failed, %0d errors", tests, failed_tests, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- src/timetagging_sample_buffer.sv
// single clock; readout is always 4 timestamp beats then 16 sample beats, host trims with the write depths
`timescale 1ns/1ps
`default_nettype none

module timetagging_sample_buffer
  import rx_pkg::*;
  import buffer_pkg::*;
(
  input  logic                          ps_clk,
  input  logic                          ps_reset,
  // realtime data
  input  logic                          samples_valid,
  input  sample_batch_t                 samples_data,
  input  logic                          timestamps_valid,
  input  tstamp_t                       timestamps_data,
  input  logic                          digital_trigger,
  output logic                          discriminator_reset,
  // software control
  input  logic                          arm_start_stop_valid,
  output logic                          arm_start_stop_ready,
  input  logic [2:0]                    arm_start_stop_data,
  input  logic                          readout_start_valid,
  output logic                          readout_start_ready,
  input  logic                          capture_sw_reset,
  input  logic                          readout_sw_reset,
  // merged readout stream
  output logic                          readout_valid,
  input  logic                          readout_ready,
  output logic [AXI_MM_WIDTH-1:0]       readout_data,
  output logic                          readout_last,
  // status
  output logic [SAMPLE_DEPTH_WIDTH-1:0] samples_write_depth,
  output logic [TSTAMP_DEPTH_WIDTH-1:0] timestamps_write_depth
);

  typedef enum logic {SEL_TSTAMP, SEL_SAMPLES} readout_sel_t;

  // bit 0 is the sample buffer, bit 1 the timestamp buffer
  logic [1:0] capture_ready;
  logic [1:0] full;
  logic [1:0] hw_stop;
  logic arm;
  logic hw_start;

  logic smp_start_ready;
  logic ts_start_ready;
  logic readout_go;

  // buffer to packer
  sample_batch_t smp_data;
  tstamp_t ts_data;
  logic smp_valid, smp_ready, smp_last;
  logic ts_valid, ts_ready, ts_last;

  // packer to mux
  logic [AXI_MM_WIDTH-1:0] smp_beat;
  logic [AXI_MM_WIDTH-1:0] ts_beat;
  logic smp_beat_valid, smp_beat_ready, smp_beat_last;
  logic ts_beat_valid, ts_beat_ready, ts_beat_last;

  logic readout_flush;
  readout_sel_t sel;

  capture_control capture_control_i (
    .ps_clk, .ps_reset,
    .cmd_valid(arm_start_stop_valid), .cmd_data(arm_start_stop_data),
    .cmd_ready(arm_start_stop_ready),
    .digital_trigger, .capture_ready, .full,
    .arm, .hw_start, .discriminator_reset, .hw_stop
  );

  // both buffers must be holding data before a readout starts
  assign readout_start_ready = smp_start_ready & ts_start_ready;
  assign readout_go = readout_start_valid & readout_start_ready;

  capture_buffer #(.payload_t(sample_batch_t), .BUFFER_DEPTH(SAMPLE_BUFFER_DEPTH)) smp_buffer_i (
    .ps_clk, .ps_reset, .capture_sw_reset, .readout_sw_reset,
    .in_valid(samples_valid), .in_data(samples_data),
    .arm, .hw_start, .hw_stop(hw_stop[0]),
    .capture_ready(capture_ready[0]), .full(full[0]),
    .readout_start_valid(readout_go), .readout_start_ready(smp_start_ready),
    .out_valid(smp_valid), .out_data(smp_data), .out_last(smp_last), .out_ready(smp_ready),
    .write_depth(samples_write_depth)
  );

  capture_buffer #(.payload_t(tstamp_t), .BUFFER_DEPTH(TSTAMP_BUFFER_DEPTH)) ts_buffer_i (
    .ps_clk, .ps_reset, .capture_sw_reset, .readout_sw_reset,
    .in_valid(timestamps_valid), .in_data(timestamps_data),
    .arm, .hw_start, .hw_stop(hw_stop[1]),
    .capture_ready(capture_ready[1]), .full(full[1]),
    .readout_start_valid(readout_go), .readout_start_ready(ts_start_ready),
    .out_valid(ts_valid), .out_data(ts_data), .out_last(ts_last), .out_ready(ts_ready),
    .write_depth(timestamps_write_depth)
  );

  // packers clear one cycle after the buffers, catching a word taken in the reset cycle
  always_ff @(posedge ps_clk) begin
    if (ps_reset) begin
      readout_flush <= 1'b0;
    end else begin
      readout_flush <= readout_sw_reset;
    end
  end

  width_packer #(.DWIDTH_IN(DATA_WIDTH), .DWIDTH_OUT(AXI_MM_WIDTH)) smp_packer_i (
    .ps_clk, .ps_reset, .flush(readout_flush),
    .in_valid(smp_valid), .in_data(smp_data), .in_last(smp_last), .in_ready(smp_ready),
    .out_valid(smp_beat_valid), .out_data(smp_beat), .out_last(smp_beat_last),
    .out_ready(smp_beat_ready)
  );

  width_packer #(.DWIDTH_IN(TSTAMP_WIDTH), .DWIDTH_OUT(AXI_MM_WIDTH)) ts_packer_i (
    .ps_clk, .ps_reset, .flush(readout_flush),
    .in_valid(ts_valid), .in_data(ts_data), .in_last(ts_last), .in_ready(ts_ready),
    .out_valid(ts_beat_valid), .out_data(ts_beat), .out_last(ts_beat_last),
    .out_ready(ts_beat_ready)
  );

  ////////////////////////////////////////
  // output mux, timestamps then samples
  ////////////////////////////////////////

  always_ff @(posedge ps_clk) begin
    if (ps_reset || readout_sw_reset) begin
      sel <= SEL_TSTAMP;
    end else if ((sel == SEL_TSTAMP) && ts_beat_valid && ts_beat_ready && ts_beat_last) begin
      sel <= SEL_SAMPLES;
    end else if ((sel == SEL_SAMPLES) && smp_beat_valid && smp_beat_ready && smp_beat_last) begin
      sel <= SEL_TSTAMP;
    end
  end

  // stale beats stay hidden while the packers are being flushed
  assign readout_valid = ~readout_flush & ((sel == SEL_SAMPLES) ? smp_beat_valid : ts_beat_valid);
  assign readout_data = (sel == SEL_SAMPLES) ? smp_beat : ts_beat;
  // the timestamp last only ends the first phase
  assign readout_last = (sel == SEL_SAMPLES) & smp_beat_last;

  assign ts_beat_ready = (sel == SEL_TSTAMP) & readout_ready & ~readout_flush;
  assign smp_beat_ready = (sel == SEL_SAMPLES) & readout_ready & ~readout_flush;

endmodule

`default_nettype wire

//--- src/width_packer.sv
// DWIDTH_OUT must be a multiple of DWIDTH_IN; lanes after an early last are sent as zero
`timescale 1ns/1ps
`default_nettype none

module width_packer
  import rx_pkg::*;
#(
  parameter int DWIDTH_IN = DATA_WIDTH,
  parameter int DWIDTH_OUT = AXI_MM_WIDTH
) (
  input  logic                  ps_clk,
  input  logic                  ps_reset,
  // drops a partial beat and any beat waiting at the output
  input  logic                  flush,
  input  logic                  in_valid,
  input  logic [DWIDTH_IN-1:0]  in_data,
  input  logic                  in_last,
  output logic                  in_ready,
  output logic                  out_valid,
  output logic [DWIDTH_OUT-1:0] out_data,
  output logic                  out_last,
  input  logic                  out_ready
);

  localparam int RATIO = DWIDTH_OUT / DWIDTH_IN;
  localparam int IDX_WIDTH = (RATIO > 1) ? $clog2(RATIO) : 1;
  localparam logic [IDX_WIDTH-1:0] IDX_LAST = IDX_WIDTH'(RATIO - 1);

  // beat being assembled, first word in the low lane
  logic [DWIDTH_OUT-1:0] acc;
  logic [DWIDTH_OUT-1:0] acc_next;
  logic [IDX_WIDTH-1:0] idx;
  logic accept;
  logic beat_done;

  // input waits only while a finished beat is stuck at the output
  assign in_ready = ~out_valid | out_ready;
  assign accept = in_valid & in_ready;
  assign beat_done = accept & (in_last | (idx == IDX_LAST));

  always_comb begin
    acc_next = acc;
    acc_next[idx*DWIDTH_IN +: DWIDTH_IN] = in_data;
  end

  always_ff @(posedge ps_clk) begin
    if (ps_reset || flush) begin
      acc <= '0;
      idx <= '0;
      out_valid <= 1'b0;
      out_last <= 1'b0;
    end else begin
      if (out_valid && out_ready) begin
        out_valid <= 1'b0;
        out_last <= 1'b0;
      end
      if (beat_done) begin
        // beat complete, start the next one from clean lanes
        acc <= '0;
        idx <= '0;
        out_valid <= 1'b1;
        out_last <= in_last;
      end else if (accept) begin
        acc <= acc_next;
        idx <= idx + 1'b1;
      end
    end
  end

  // output beat, held until taken
  always_ff @(posedge ps_clk) begin
    if (beat_done) begin
      out_data <= acc_next;
    end
  end

endmodule

`default_nettype wire

//--- src/capture_buffer.sv
// depth must be a power of two; readout always sends all entries, valid or not, so the host trims by write_depth
`timescale 1ns/1ps
`default_nettype none

module capture_buffer
  import rx_pkg::*;
  import buffer_pkg::*;
#(
  parameter type payload_t = sample_batch_t,
  parameter int BUFFER_DEPTH = SAMPLE_BUFFER_DEPTH
) (
  input  logic     ps_clk,
  input  logic     ps_reset,
  input  logic     capture_sw_reset,
  input  logic     readout_sw_reset,
  // realtime input, no back-pressure
  input  logic     in_valid,
  input  payload_t in_data,
  // control pulses
  input  logic     arm,
  input  logic     hw_start,
  input  logic     hw_stop,
  output logic     capture_ready,
  output logic     full,
  // readout command
  input  logic     readout_start_valid,
  output logic     readout_start_ready,
  // entry stream toward the packer
  output logic     out_valid,
  output payload_t out_data,
  output logic     out_last,
  input  logic     out_ready,
  // entries stored in the current capture
  output logic [$clog2(BUFFER_DEPTH+1)-1:0] write_depth
);

  localparam int ADDR_WIDTH = $clog2(BUFFER_DEPTH);
  localparam int DEPTH_WIDTH = $clog2(BUFFER_DEPTH + 1);
  localparam logic [DEPTH_WIDTH-1:0] DEPTH_MAX = DEPTH_WIDTH'(BUFFER_DEPTH);
  localparam logic [DEPTH_WIDTH-1:0] DEPTH_LAST = DEPTH_WIDTH'(BUFFER_DEPTH - 1);

  capture_state_t state;

  // write side
  logic [DEPTH_WIDTH-1:0] wr_count;
  logic wr_en;

  // entry memory with a one-cycle registered read
  payload_t mem [BUFFER_DEPTH];
  payload_t mem_q;

  // read side, rd_count counts issued reads
  logic [DEPTH_WIDTH-1:0] rd_count;
  logic rd_issue;
  logic rd_pending;
  logic rd_pending_last;
  logic readout_go;
  logic readout_done;

  // two-entry output register
  payload_t skid_data [2];
  logic [1:0] skid_last;
  logic skid_wr_ptr;
  logic skid_rd_ptr;
  logic [1:0] skid_count;
  logic [2:0] occupancy;
  logic pop;

  ////////////////////////////////////////
  // capture FSM
  ////////////////////////////////////////

  // start/stop commands are only taken while no data is held
  assign capture_ready = (state != HOLD) && (state != READOUT);
  assign full = (wr_count == DEPTH_MAX);
  assign write_depth = wr_count;

  assign readout_start_ready = (state == HOLD);
  assign readout_go = readout_start_valid & readout_start_ready;

  // stop wins over a word arriving in the same cycle
  assign wr_en = (state == CAPTURE) && in_valid && !hw_stop && (wr_count != DEPTH_MAX);

  always_ff @(posedge ps_clk) begin
    if (ps_reset || capture_sw_reset) begin
      state <= IDLE;
    end else if (readout_sw_reset && (state == READOUT)) begin
      // captured data stays, only the readout starts over
      state <= HOLD;
    end else begin
      case (state)
        IDLE: begin
          if (arm) begin
            state <= ARMED;
          end
        end
        ARMED: begin
          if (hw_start) begin
            state <= CAPTURE;
          end
        end
        CAPTURE: begin
          // leave on an external stop or on the write that fills the memory
          if (hw_stop || (wr_en && (wr_count == DEPTH_LAST))) begin
            state <= HOLD;
          end
        end
        HOLD: begin
          if (readout_go) begin
            state <= READOUT;
          end
        end
        READOUT: begin
          if (readout_done) begin
            state <= IDLE;
          end
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge ps_clk) begin
    if (ps_reset || capture_sw_reset) begin
      wr_count <= '0;
    end else if ((state == IDLE) && arm) begin
      // a new arm discards the previous capture count
      wr_count <= '0;
    end else if (wr_en) begin
      wr_count <= wr_count + 1'b1;
    end
  end

  ////////////////////////////////////////
  // memory
  ////////////////////////////////////////

  always_ff @(posedge ps_clk) begin
    if (wr_en) begin
      mem[wr_count[ADDR_WIDTH-1:0]] <= in_data;
    end
    // read address follows rd_count, data lands one cycle after issue
    mem_q <= mem[rd_count[ADDR_WIDTH-1:0]];
  end

  ////////////////////////////////////////
  // readout
  ////////////////////////////////////////

  assign pop = out_valid & out_ready;
  assign readout_done = pop & out_last;

  // words held plus the one coming out of memory
  assign occupancy = {1'b0, skid_count} + {2'b00, rd_pending};

  // issue only if the output register can take the word next cycle
  assign rd_issue = (state == READOUT) && (rd_count != DEPTH_MAX) &&
                    (occupancy <= (3'd1 + {2'b00, pop}));

  always_ff @(posedge ps_clk) begin
    if (ps_reset || capture_sw_reset || readout_sw_reset || (state != READOUT)) begin
      rd_count <= '0;
      rd_pending <= 1'b0;
      rd_pending_last <= 1'b0;
      skid_wr_ptr <= 1'b0;
      skid_rd_ptr <= 1'b0;
      skid_count <= '0;
    end else begin
      if (rd_issue) begin
        rd_count <= rd_count + 1'b1;
      end
      rd_pending <= rd_issue;
      // tag the final address so last rides with its word
      rd_pending_last <= rd_issue && (rd_count == DEPTH_LAST);
      if (rd_pending) begin
        skid_wr_ptr <= ~skid_wr_ptr;
      end
      if (pop) begin
        skid_rd_ptr <= ~skid_rd_ptr;
      end
      skid_count <= skid_count + {1'b0, rd_pending} - {1'b0, pop};
    end
  end

  // payload slots, qualified by skid_count
  always_ff @(posedge ps_clk) begin
    if (rd_pending) begin
      skid_data[skid_wr_ptr] <= mem_q;
      skid_last[skid_wr_ptr] <= rd_pending_last;
    end
  end

  assign out_valid = (skid_count != 2'd0);
  assign out_data = skid_data[skid_rd_ptr];
  assign out_last = skid_last[skid_rd_ptr];

endmodule

`default_nettype wire

//--- src/capture_control.sv
// commands are {arm, start, stop}; a start must come with arm and stop is ignored outside capture
`timescale 1ns/1ps
`default_nettype none

module capture_control
  import buffer_pkg::*;
(
  input  logic       ps_clk,
  input  logic       ps_reset,
  // command stream from software
  input  logic       cmd_valid,
  input  logic [2:0] cmd_data,
  output logic       cmd_ready,
  // realtime trigger from the trigger manager
  input  logic       digital_trigger,
  // per buffer status, bit 0 samples and bit 1 timestamps
  input  logic [1:0] capture_ready,
  input  logic [1:0] full,
  // pulses to the buffers
  output logic       arm,
  output logic       hw_start,
  output logic       discriminator_reset,
  output logic [1:0] hw_stop
);

  logic cmd_accept;
  // command held for one cycle so start lands after arm
  logic pend_valid;
  logic pend_start;
  logic pend_stop;
  // software start/stop as applied
  logic sw_start;
  logic sw_stop;
  // start or trigger travelling toward hw_start
  logic [DISC_LATENCY-1:0] start_pipe;

  ////////////////////////////////////////
  // command acceptance
  ////////////////////////////////////////

  // no new command while one is in flight or a buffer holds data
  assign cmd_ready = ~pend_valid & (&capture_ready);
  assign cmd_accept = cmd_valid & cmd_ready;

  always_ff @(posedge ps_clk) begin
    if (ps_reset) begin
      arm <= 1'b0;
      pend_valid <= 1'b0;
      pend_start <= 1'b0;
      pend_stop <= 1'b0;
      sw_start <= 1'b0;
      sw_stop <= 1'b0;
    end else begin
      // arm goes out right away, bit 2
      arm <= cmd_accept & cmd_data[2];
      pend_valid <= cmd_accept;
      // start is bit 1 and stop bit 0
      pend_start <= cmd_accept & cmd_data[1];
      pend_stop <= cmd_accept & cmd_data[0];
      // second stage, one cycle behind arm
      sw_start <= pend_start;
      sw_stop <= pend_stop;
    end
  end

  ////////////////////////////////////////
  // discriminator reset and start delay
  ////////////////////////////////////////

  // trigger path is combinational so the discriminator sees it in the same cycle
  assign discriminator_reset = sw_start | digital_trigger;

  always_ff @(posedge ps_clk) begin
    if (ps_reset) begin
      start_pipe <= '0;
    end else begin
      start_pipe <= {start_pipe[DISC_LATENCY-2:0], discriminator_reset};
    end
  end

  // buffers start once the discriminator has settled
  assign hw_start = start_pipe[DISC_LATENCY-1];

  // either buffer filling ends capture in the other one too
  assign hw_stop[0] = sw_stop | full[1];
  assign hw_stop[1] = sw_stop | full[0];

endmodule

`default_nettype wire

//--- src/buffer_pkg.sv
// buffer depths must be powers of two and DISC_LATENCY at least 2 for the start delay line
`default_nettype none

package buffer_pkg;

  // sample batches held per capture
  localparam int SAMPLE_BUFFER_DEPTH = 32;
  // timestamps held per capture
  localparam int TSTAMP_BUFFER_DEPTH = 16;

  // write-depth counts run from 0 up to the full depth inclusive
  localparam int SAMPLE_DEPTH_WIDTH = $clog2(SAMPLE_BUFFER_DEPTH + 1);
  localparam int TSTAMP_DEPTH_WIDTH = $clog2(TSTAMP_BUFFER_DEPTH + 1);

  // cycles between discriminator reset and the hardware start
  localparam int DISC_LATENCY = 4;

  // capture FSM states shared by both buffers
  typedef enum logic [2:0] {
    IDLE,
    ARMED,
    CAPTURE,
    HOLD,
    READOUT
  } capture_state_t;

endpackage

`default_nettype wire

//--- src/rx_pkg.sv
// stream widths for a two-sample ADC front end; the readout bus width must be a multiple of each entry
`default_nettype none

package rx_pkg;

  // one ADC sample straight from the converter
  localparam int SAMPLE_WIDTH = 16;
  // samples delivered together on every valid cycle
  localparam int PARALLEL_SAMPLES = 2;
  // one batch entry, sample n in the low half
  localparam int DATA_WIDTH = SAMPLE_WIDTH * PARALLEL_SAMPLES;
  // one timestamp entry
  localparam int TSTAMP_WIDTH = 16;
  // host readout bus
  localparam int AXI_MM_WIDTH = 64;

  typedef logic [DATA_WIDTH-1:0] sample_batch_t;
  typedef logic [TSTAMP_WIDTH-1:0] tstamp_t;

endpackage

`default_nettype wire
